// ==== verilog/ma_pkg.sv ====
`default_nettype none

package ma_pkg;

    localparam int DATA_W    = 32;
    localparam int ADDR_W    = 32;
    localparam int RAM_WORDS = 256;
    localparam int MEM_LAT   = 2;
    localparam int IDX_W     = 5;
    // latency counter width, holds 0..MEM_LAT
    localparam int LAT_W     = $clog2(MEM_LAT + 1);

    // access code from the execute stage
    typedef enum logic [1:0] {
        OP_NONE   = 2'b00,
        OP_STORE  = 2'b01,
        OP_LOAD_S = 2'b10,
        OP_LOAD_U = 2'b11
    } ma_op_e;

    // 2'b10 is illegal
    typedef enum logic [1:0] {
        LEN_BYTE = 2'b00,
        LEN_HALF = 2'b01,
        LEN_WORD = 2'b11
    } ma_len_e;

    typedef struct packed {
        ma_op_e              op;
        ma_len_e             len;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   din;
        logic                wb_e;
        logic [IDX_W-1:0]    wb_idx;
    } ma_req_t;

    typedef struct packed {
        logic                wb_e;
        logic [IDX_W-1:0]    wb_idx;
        logic [DATA_W-1:0]   value;
    } ma_wb_t;

    typedef struct packed {
        logic [IDX_W-1:0]    idx;
        logic [DATA_W-1:0]   value;
    } ma_fwd_t;

    typedef struct packed {
        logic                re;
        logic                we;
        ma_len_e             len;
        logic [ADDR_W-1:0]   addr;
        logic [DATA_W-1:0]   wdata;
    } mem_cmd_t;

    // one memory word, seen as byte lanes or half lanes
    typedef union packed {
        logic [3:0][7:0]     byte_lane;
        logic [1:0][15:0]    half_lane;
    } mem_word_u;

endpackage

`default_nettype wire

// ==== verilog/load_format.sv ====
`timescale 1ns/100ps
`default_nettype none

module load_format (
    input  wire ma_pkg::mem_word_u       word,
    input  wire logic [1:0]              addr_lo,
    input  wire ma_pkg::ma_len_e         len,
    input  wire logic                    is_signed,
    output logic [ma_pkg::DATA_W-1:0]    value
);
    import ma_pkg::*;

    logic [7:0]  lane_b;
    logic [15:0] lane_h;
    logic        ext_b;
    logic        ext_h;

    // lane select from the low address bits
    assign lane_b = word.byte_lane[addr_lo];
    assign lane_h = word.half_lane[addr_lo[1]];

    // fill bit is zero for unsigned loads
    assign ext_b = is_signed & lane_b[7];
    assign ext_h = is_signed & lane_h[15];

    always_comb begin
        case (len)
            LEN_BYTE: begin
                value = {{(DATA_W-8){ext_b}}, lane_b};
            end
            LEN_HALF: begin
                value = {{(DATA_W-16){ext_h}}, lane_h};
            end
            LEN_WORD: begin
                value = word;
            end
            default: begin
                // illegal length, pass the raw word
                value = word;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/mem_wait_timer.sv ====
`timescale 1ns/100ps
`default_nettype none

module mem_wait_timer (
    input  wire logic  buf_avail,
    input  wire logic  rst,
    input  wire logic  start,
    output logic       done
);
    import ma_pkg::*;

    logic [LAT_W-1:0] cnt;

    // zero means idle, so the last count is the one where done fires
    assign done = (cnt == LAT_W'(1));

    always_ff @(posedge buf_avail or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (start) begin
            cnt <= LAT_W'(MEM_LAT);
        end else if (cnt != '0) begin
            cnt <= cnt - 1'b1;
        end
    end

    // the sequencer must not restart a running count
    a_no_restart: assert property (@(posedge buf_avail) disable iff (rst)
        start |-> (cnt == '0))
        else $error("timer started while counting, cnt=%0d", cnt);

endmodule

`default_nettype wire

// ==== verilog/ma_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

module ma_sequencer (
    input  wire logic             buf_avail,
    input  wire logic             rst,
    input  wire logic             in_avail,
    input  wire ma_pkg::ma_op_e   op,
    input  wire logic             wb_full,
    input  wire logic             wait_done,
    output logic                  buf_re,
    output logic                  capture,
    output logic                  mem_re,
    output logic                  mem_we,
    output logic                  timer_start,
    output logic                  load_capture,
    output logic                  buf_we,
    output logic                  holding_load
);
    import ma_pkg::*;

    typedef enum logic [1:0] {
        IDLE   = 2'b00,
        ACCESS = 2'b01,
        WAIT   = 2'b10,
        PUSH   = 2'b11
    } seq_state_e;

    seq_state_e state;
    seq_state_e state_nx;
    ma_op_e     cur_op;
    logic       is_load;

    assign is_load = (cur_op == OP_LOAD_S) || (cur_op == OP_LOAD_U);

    // pop the head entry whenever idle and the buffer has one
    assign buf_re  = (state == IDLE) && in_avail;
    assign capture = buf_re;

    assign mem_re       = (state == ACCESS) && is_load;
    assign mem_we       = (state == ACCESS) && (cur_op == OP_STORE);
    assign timer_start  = (state == ACCESS) && (cur_op != OP_NONE);
    assign load_capture = (state == WAIT) && wait_done && is_load;

    // push waits out back-pressure in PUSH
    assign buf_we       = (state == PUSH) && !wb_full;
    assign holding_load = (state == PUSH) && is_load;

    always_comb begin
        state_nx = state;
        case (state)
            IDLE: begin
                if (in_avail) begin
                    state_nx = ACCESS;
                end
            end
            ACCESS: begin
                // none ops skip the memory entirely
                state_nx = (cur_op == OP_NONE) ? PUSH : WAIT;
            end
            WAIT: begin
                if (wait_done) begin
                    state_nx = PUSH;
                end
            end
            PUSH: begin
                if (!wb_full) begin
                    state_nx = IDLE;
                end
            end
            default: state_nx = IDLE;
        endcase
    end

    always_ff @(posedge buf_avail or posedge rst) begin
        if (rst) begin
            state  <= IDLE;
            cur_op <= OP_NONE;
        end else begin
            state <= state_nx;
            if (capture) begin
                cur_op <= op;
            end
        end
    end

    a_no_pop_and_push: assert property (@(posedge buf_avail) disable iff (rst)
        !(buf_re && buf_we))
        else $error("buf_re and buf_we high together");

    a_re_single: assert property (@(posedge buf_avail) disable iff (rst)
        buf_re |=> !buf_re)
        else $error("buf_re held two cycles");

    a_we_single: assert property (@(posedge buf_avail) disable iff (rst)
        buf_we |=> !buf_we)
        else $error("buf_we held two cycles");

    a_mem_single: assert property (@(posedge buf_avail) disable iff (rst)
        (mem_re || mem_we) |=> !(mem_re || mem_we))
        else $error("memory strobe held two cycles");

endmodule

`default_nettype wire

// ==== verilog/data_ram.sv ====
`timescale 1ns/100ps
`default_nettype none

module data_ram (
    input  wire logic               buf_avail,
    input  wire ma_pkg::mem_cmd_t   cmd,
    output ma_pkg::mem_word_u       rdata
);
    import ma_pkg::*;

    mem_word_u                      mem [RAM_WORDS];
    logic [$clog2(RAM_WORDS)-1:0]   idx;
    logic [1:0]                     lo;
    mem_word_u                      wr_word;
    logic [3:0]                     be;

    assign idx = cmd.addr[2 +: $clog2(RAM_WORDS)];
    assign lo  = cmd.addr[1:0];

    // replicate the low bytes of wdata into every lane, then enable the addressed ones
    always_comb begin
        wr_word.byte_lane = {4{cmd.wdata[7:0]}};
        be = 4'b0000;
        case (cmd.len)
            LEN_BYTE: begin
                be = 4'b0001 << lo;
            end
            LEN_HALF: begin
                wr_word.half_lane = {2{cmd.wdata[15:0]}};
                be = lo[1] ? 4'b1100 : 4'b0011;
            end
            LEN_WORD: begin
                wr_word.half_lane = cmd.wdata;
                be = 4'b1111;
            end
            default: begin
                be = 4'b0000;
            end
        endcase
    end

    always_ff @(posedge buf_avail) begin
        if (cmd.we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    mem[idx].byte_lane[i] <= wr_word.byte_lane[i];
                end
            end
        end
        // whole aligned word, held until the next read
        if (cmd.re) begin
            rdata <= mem[idx];
        end
    end

    a_cmd_legal: assert property (@(posedge buf_avail)
        (cmd.re || cmd.we) |->
            (cmd.len != 2'b10) &&
            (cmd.len != LEN_HALF || !cmd.addr[0]) &&
            (cmd.len != LEN_WORD || cmd.addr[1:0] == 2'b00))
        else $error("bad access len=%b addr=%h", cmd.len, cmd.addr);

endmodule

`default_nettype wire

// ==== verilog/ma_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

module ma_stage (
    input  wire logic                buf_avail,
    input  wire logic                rst,
    input  wire logic                in_avail,
    input  wire ma_pkg::ma_req_t     in_req,
    output logic                     buf_re,
    input  wire logic                wb_full,
    output logic                     buf_we,
    output ma_pkg::ma_wb_t           wb_res,
    output ma_pkg::ma_fwd_t          fwd,
    output ma_pkg::mem_cmd_t         mem_cmd,
    input  wire ma_pkg::mem_word_u   mem_rdata
);
    import ma_pkg::*;

    ma_req_t             req_q;
    logic [DATA_W-1:0]   res_q;
    logic [DATA_W-1:0]   fmt_value;
    logic                capture;
    logic                mem_re;
    logic                mem_we;
    logic                timer_start;
    logic                wait_done;
    logic                load_capture;
    logic                holding_load;

    ma_sequencer seq_i (
        .buf_avail    (buf_avail),
        .rst          (rst),
        .in_avail     (in_avail),
        .op           (in_req.op),
        .wb_full      (wb_full),
        .wait_done    (wait_done),
        .buf_re       (buf_re),
        .capture      (capture),
        .mem_re       (mem_re),
        .mem_we       (mem_we),
        .timer_start  (timer_start),
        .load_capture (load_capture),
        .buf_we       (buf_we),
        .holding_load (holding_load)
    );

    mem_wait_timer timer_i (
        .buf_avail (buf_avail),
        .rst       (rst),
        .start     (timer_start),
        .done      (wait_done)
    );

    load_format fmt_i (
        .word      (mem_rdata),
        .addr_lo   (req_q.addr[1:0]),
        .len       (req_q.len),
        .is_signed (req_q.op == OP_LOAD_S),
        .value     (fmt_value)
    );

    // request held for the whole access
    always_ff @(posedge buf_avail) begin
        if (capture) begin
            req_q <= in_req;
        end
    end

    // none ops write back the execute result, loads the formatted word
    always_ff @(posedge buf_avail) begin
        if (capture && in_req.op == OP_NONE) begin
            res_q <= in_req.addr;
        end else if (load_capture) begin
            res_q <= fmt_value;
        end
    end

    always_comb begin
        mem_cmd.re    = mem_re;
        mem_cmd.we    = mem_we;
        mem_cmd.len   = req_q.len;
        mem_cmd.addr  = req_q.addr;
        mem_cmd.wdata = req_q.din;
    end

    always_comb begin
        wb_res.wb_e   = req_q.wb_e;
        wb_res.wb_idx = req_q.wb_idx;
        wb_res.value  = res_q;
    end

    // only a held load result is forwarded
    always_comb begin
        fwd.idx   = (holding_load && req_q.wb_e) ? req_q.wb_idx : '0;
        fwd.value = res_q;
    end

    a_push_not_full: assert property (@(posedge buf_avail) disable iff (rst)
        buf_we |-> !wb_full)
        else $error("buf_we pulsed while wb_full high");

endmodule

`default_nettype wire

// ==== verilog/ma_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module ma_top (
    input  wire logic               buf_avail,
    input  wire logic               rst,
    input  wire logic               in_avail,
    input  wire ma_pkg::ma_req_t    in_req,
    output logic                    buf_re,
    input  wire logic               wb_full,
    output logic                    buf_we,
    output ma_pkg::ma_wb_t          wb_res,
    output ma_pkg::ma_fwd_t         fwd
);

    // stage to memory
    ma_pkg::mem_cmd_t   mem_cmd;
    ma_pkg::mem_word_u  mem_rdata;

    ma_stage stage_i (
        .buf_avail (buf_avail),
        .rst       (rst),
        .in_avail  (in_avail),
        .in_req    (in_req),
        .buf_re    (buf_re),
        .wb_full   (wb_full),
        .buf_we    (buf_we),
        .wb_res    (wb_res),
        .fwd       (fwd),
        .mem_cmd   (mem_cmd),
        .mem_rdata (mem_rdata)
    );

    data_ram ram_i (
        .buf_avail (buf_avail),
        .cmd       (mem_cmd),
        .rdata     (mem_rdata)
    );

endmodule

`default_nettype wire

// ==== test/ma_tests.svh ====
`ifndef MA_TESTS_SVH
`define MA_TESTS_SVH

task automatic test_reset_values();
    @(negedge buf_avail);
    check_true(!buf_re && !buf_we, "buf_re or buf_we high during reset");
    check_true(!dut_i.mem_cmd.re && !dut_i.mem_cmd.we, "memory strobe high during reset");
    check_val("fwd.idx", DATA_W'(fwd.idx), '0);
endtask

// pop one request from the modeled input buffer and wait for its push
task automatic run_req(input ma_req_t req, output ma_wb_t res, output int lat);
    int   n;
    int   re_at;
    int   we_at;
    int   re_seen;
    int   we_seen;
    logic is_load;
    n       = 0;
    re_at   = -1;
    we_at   = -1;
    re_seen = 0;
    we_seen = 0;
    res     = '0;
    is_load = (req.op == OP_LOAD_S) || (req.op == OP_LOAD_U);
    @(posedge buf_avail);
    in_avail <= 1'b1;
    in_req   <= req;
    while (we_at < 0 && n < 2 * REQ_LIMIT) begin
        @(negedge buf_avail);
        n++;
        // only a load held in push may forward its index
        if (is_load && buf_we) begin
            check_val("fwd.idx", DATA_W'(fwd.idx), DATA_W'(req.wb_e ? req.wb_idx : IDX_W'(0)));
        end else begin
            check_val("fwd.idx", DATA_W'(fwd.idx), '0);
        end
        if (buf_we) begin
            we_seen++;
            we_at = n;
            res   = wb_res;
        end
        if (buf_re) begin
            re_seen++;
            re_at = n;
            @(posedge buf_avail);
            in_avail <= 1'b0;
        end
    end
    // one more cycle to catch a repeated pulse
    @(negedge buf_avail);
    re_seen += int'(buf_re);
    we_seen += int'(buf_we);
    check_true(we_at >= 0, "no buf_we within the request time limit");
    check_true(re_seen == 1, "expected exactly one buf_re for the request");
    check_true(we_seen == 1, "expected exactly one buf_we for the request");
    check_val("wb_res.wb_e", DATA_W'(res.wb_e), DATA_W'(req.wb_e));
    check_val("wb_res.wb_idx", DATA_W'(res.wb_idx), DATA_W'(req.wb_idx));
    lat = we_at - re_at;
endtask

task automatic do_store(input logic [ADDR_W-1:0] addr, input ma_len_e len,
                        input logic [DATA_W-1:0] data);
    ma_wb_t res;
    int     lat;
    run_req(make_req(OP_STORE, len, addr, data, 1'b1, IDX_W'($random(seed))), res, lat);
    check_val("buf_we cycle after buf_re", DATA_W'(lat), DATA_W'(MEM_LAT + 2));
    ref_store(addr, len, data);
endtask

task automatic do_load(input logic [ADDR_W-1:0] addr, input ma_len_e len,
                       input logic is_signed);
    ma_wb_t res;
    int     lat;
    ma_op_e op;
    op = is_signed ? OP_LOAD_S : OP_LOAD_U;
    run_req(make_req(op, len, addr, '0, 1'b1, IDX_W'($random(seed))), res, lat);
    check_val("buf_we cycle after buf_re", DATA_W'(lat), DATA_W'(MEM_LAT + 2));
    check_val("wb_res.value", res.value, ref_load(addr, len, is_signed));
endtask

task automatic test_none_op();
    ma_req_t req;
    ma_wb_t  res;
    int      lat;
    for (int i = 0; i < 4; i++) begin
        req = make_req(OP_NONE, LEN_WORD, $random(seed), $random(seed), i[0], IDX_W'(i + 3));
        run_req(req, res, lat);
        check_val("wb_res.value", res.value, req.addr);
        check_val("buf_we cycle after buf_re", DATA_W'(lat), 2);
    end
endtask

task automatic test_word_store_load();
    logic [ADDR_W-1:0] a;
    for (int i = 0; i < 4; i++) begin
        a = 32'h40 + 36 * i;
        do_store(a, LEN_WORD, $random(seed));
        do_load(a, LEN_WORD, i[0]);
    end
endtask

task automatic test_signed_loads();
    // junk in the upper bits must not reach memory
    for (int k = 0; k < 4; k++) begin
        do_store(32'h100 + k, LEN_BYTE, {24'ha5a5a5, 8'(8'h80 + k * 17)});
    end
    for (int k = 0; k < 4; k++) begin
        do_load(32'h100 + k, LEN_BYTE, 1'b1);
    end
    for (int k = 0; k < 2; k++) begin
        do_store(32'h110 + 2 * k, LEN_HALF, {16'h5a5a, 16'(16'h9000 + k * 16'h1234)});
        do_load(32'h110 + 2 * k, LEN_HALF, 1'b1);
    end
endtask

task automatic test_unsigned_loads();
    for (int k = 0; k < 4; k++) begin
        do_load(32'h100 + k, LEN_BYTE, 1'b0);
    end
    for (int k = 0; k < 2; k++) begin
        do_load(32'h110 + 2 * k, LEN_HALF, 1'b0);
    end
    // partial stores must leave the other lanes alone
    do_store(32'h120, LEN_WORD, 32'h1234_5678);
    do_store(32'h121, LEN_BYTE, 32'hffff_ffab);
    do_store(32'h123, LEN_BYTE, 32'h0000_00cd);
    do_load(32'h120, LEN_WORD, 1'b0);
    do_store(32'h122, LEN_HALF, 32'hdead_beef);
    do_load(32'h120, LEN_WORD, 1'b1);
endtask

// hold a load result under wb_full with another entry waiting at the head
task automatic hold_and_release(input ma_req_t req, input ma_req_t next_req, input int hold);
    ma_wb_t            held;
    logic [DATA_W-1:0] exp;
    int                n;
    int                we_seen;
    exp     = ref_load(req.addr, req.len, req.op == OP_LOAD_S);
    n       = 0;
    we_seen = 0;
    @(posedge buf_avail);
    wb_full  <= 1'b1;
    in_avail <= 1'b1;
    in_req   <= req;
    @(negedge buf_avail);
    while (!buf_re && n < REQ_LIMIT) begin
        @(negedge buf_avail);
        n++;
    end
    check_true(buf_re, "held request was not popped");
    @(posedge buf_avail);
    in_req <= next_req;
    repeat (MEM_LAT + 2) begin
        @(negedge buf_avail);
        check_true(!buf_re && !buf_we, "strobe before the held result settled");
    end
    held = wb_res;
    check_val("wb_res.value", held.value, exp);
    repeat (hold) begin
        @(negedge buf_avail);
        check_true(!buf_re, "buf_re pulsed under back-pressure");
        check_true(!buf_we, "buf_we pulsed while wb_full was high");
        check_val("wb_res.value", wb_res.value, exp);
        check_val("wb_res.wb_idx", DATA_W'(wb_res.wb_idx), DATA_W'(req.wb_idx));
        check_val("fwd.idx", DATA_W'(fwd.idx), DATA_W'(req.wb_e ? req.wb_idx : IDX_W'(0)));
        check_val("fwd.value", fwd.value, exp);
    end
    @(posedge buf_avail);
    wb_full <= 1'b0;
    n = 0;
    while (!buf_re && n < REQ_LIMIT) begin
        @(negedge buf_avail);
        n++;
        if (buf_we) begin
            we_seen++;
            check_val("wb_res.value", wb_res.value, exp);
            check_val("wb_res.wb_idx", DATA_W'(wb_res.wb_idx), DATA_W'(req.wb_idx));
        end
    end
    check_true(we_seen == 1, "expected exactly one buf_we after wb_full was released");
    // the waiting entry is a none op
    @(posedge buf_avail);
    in_avail <= 1'b0;
    n       = 0;
    we_seen = 0;
    while (we_seen == 0 && n < REQ_LIMIT) begin
        @(negedge buf_avail);
        n++;
        if (buf_we) begin
            we_seen++;
            check_val("wb_res.value", wb_res.value, next_req.addr);
        end
    end
    check_true(we_seen == 1, "waiting none op was not pushed");
endtask

task automatic test_backpressure();
    hold_and_release(make_req(OP_LOAD_U, LEN_HALF, 32'h112, '0, 1'b0, 5'd9),
                     make_req(OP_NONE, LEN_WORD, 32'h0bad_f00d, '0, 1'b1, 5'd4), 6);
endtask

task automatic random_access();
    ma_len_e           len;
    logic [ADDR_W-1:0] addr;
    int                pick;
    pick = int'($unsigned($random(seed)) % 3);
    len  = (pick == 0) ? LEN_BYTE : (pick == 1) ? LEN_HALF : LEN_WORD;
    addr = RND_BASE + ($unsigned($random(seed)) % 64);
    // align to the access length
    if (len == LEN_HALF) begin
        addr[0] = 1'b0;
    end
    if (len == LEN_WORD) begin
        addr[1:0] = 2'b00;
    end
    pick = int'($unsigned($random(seed)) % 3);
    if (pick == 0) begin
        do_store(addr, len, $random(seed));
    end else begin
        do_load(addr, len, pick == 1);
    end
endtask

task automatic test_forwarding_random();
    ma_wb_t res;
    int     lat;
    hold_and_release(make_req(OP_LOAD_S, LEN_BYTE, 32'h101, '0, 1'b1, 5'd17),
                     make_req(OP_NONE, LEN_WORD, 32'h0000_1234, '0, 1'b0, 5'd2), 5);
    // fwd.idx stays zero for these, checked inside run_req
    do_store(32'h130, LEN_WORD, 32'hcafe_0001);
    run_req(make_req(OP_NONE, LEN_WORD, 32'h0000_0130, '0, 1'b1, 5'd30), res, lat);
    // every word of the random window starts out defined
    for (int w = 0; w < 16; w++) begin
        do_store(RND_BASE + 4 * w, LEN_WORD, $random(seed));
    end
    for (int i = 0; i < 200; i++) begin
        random_access();
    end
endtask

`endif

// ==== test/tb_ma.sv ====
`timescale 1ns/100ps
`default_nettype none

module tb_ma;
    import ma_pkg::*;

    localparam int CLK_PERIOD = 4;
    // requests issued by all tests, rounded up
    localparam int N_REQ      = 300;
    localparam int REQ_LIMIT  = MEM_LAT + 8;
    localparam int BYTE_AW    = $clog2(RAM_WORDS * 4);
    localparam logic [ADDR_W-1:0] RND_BASE = 32'h200;

    logic       buf_avail = 1'b0;
    logic       rst;
    logic       in_avail;
    ma_req_t    in_req;
    logic       buf_re;
    logic       wb_full;
    logic       buf_we;
    ma_wb_t     wb_res;
    ma_fwd_t    fwd;

    int         seed;
    int         check_cnt;
    int         mismatch_cnt;
    int         fail_cnt;
    // byte-wide reference memory, little-endian
    logic [7:0] ref_mem [RAM_WORDS * 4];

    ma_top dut_i (
        .buf_avail (buf_avail),
        .rst       (rst),
        .in_avail  (in_avail),
        .in_req    (in_req),
        .buf_re    (buf_re),
        .wb_full   (wb_full),
        .buf_we    (buf_we),
        .wb_res    (wb_res),
        .fwd       (fwd)
    );

    always #(CLK_PERIOD / 2) buf_avail = ~buf_avail;

    function automatic void check_val(string name, logic [DATA_W-1:0] got,
                                      logic [DATA_W-1:0] exp);
        check_cnt++;
        assert (got === exp) else begin
            $display("Mismatch %s: got %h, expected %h at %0t", name, got, exp, $time);
            mismatch_cnt++;
        end
    endfunction

    function automatic void check_true(logic cond, string what);
        check_cnt++;
        assert (cond === 1'b1) else begin
            $display("Failure: %s at %0t", what, $time);
            fail_cnt++;
        end
    endfunction

    function automatic void ref_store(logic [ADDR_W-1:0] addr, ma_len_e len,
                                      logic [DATA_W-1:0] data);
        logic [BYTE_AW-1:0] a;
        a = addr[BYTE_AW-1:0];
        ref_mem[a] = data[7:0];
        if (len != LEN_BYTE) begin
            ref_mem[a + 1'b1] = data[15:8];
        end
        if (len == LEN_WORD) begin
            ref_mem[a + 2'd2] = data[23:16];
            ref_mem[a + 2'd3] = data[31:24];
        end
    endfunction

    // expected load value from the access code and length rules
    function automatic logic [DATA_W-1:0] ref_load(logic [ADDR_W-1:0] addr, ma_len_e len,
                                                   logic is_signed);
        logic [BYTE_AW-1:0] a;
        logic [7:0]         b0;
        logic [7:0]         b1;
        logic [DATA_W-1:0]  v;
        a  = addr[BYTE_AW-1:0];
        b0 = ref_mem[a];
        b1 = ref_mem[a + 1'b1];
        case (len)
            LEN_BYTE: v = {{24{is_signed & b0[7]}}, b0};
            LEN_HALF: v = {{16{is_signed & b1[7]}}, b1, b0};
            default:  v = {ref_mem[a + 2'd3], ref_mem[a + 2'd2], b1, b0};
        endcase
        return v;
    endfunction

    function automatic ma_req_t make_req(ma_op_e op, ma_len_e len, logic [ADDR_W-1:0] addr,
                                         logic [DATA_W-1:0] din, logic wb_e,
                                         logic [IDX_W-1:0] idx);
        ma_req_t r;
        r.op     = op;
        r.len    = len;
        r.addr   = addr;
        r.din    = din;
        r.wb_e   = wb_e;
        r.wb_idx = idx;
        return r;
    endfunction

    `include "ma_tests.svh"

    initial begin
        seed         = 95725;
        check_cnt    = 0;
        mismatch_cnt = 0;
        fail_cnt     = 0;
        rst          = 1'b1;
        in_avail     = 1'b0;
        in_req       = '0;
        wb_full      = 1'b0;
        repeat (3) @(posedge buf_avail);
        test_reset_values();
        @(posedge buf_avail);
        rst <= 1'b0;
        test_none_op();
        test_word_store_load();
        test_signed_loads();
        test_unsigned_loads();
        test_backpressure();
        test_forwarding_random();
        repeat (2) @(posedge buf_avail);
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, fail_cnt);
        if (mismatch_cnt == 0 && fail_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, sized for the worst-case cycles per request
    initial begin
        #(N_REQ * REQ_LIMIT * CLK_PERIOD + 2000);
        $display("Timeout: the tests did not finish in the expected time");
        $display("checks %0d, mismatches %0d, other errors %0d",
                 check_cnt, mismatch_cnt, fail_cnt + 1);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+test
verilog/ma_pkg.sv
verilog/load_format.sv
verilog/mem_wait_timer.sv
verilog/ma_sequencer.sv
verilog/data_ram.sv
verilog/ma_stage.sv
verilog/ma_top.sv
test/tb_ma.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := tb_ma
FILELIST   := project.f
BUILD_DIR  := obj_dir
LOG        := sim.log
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only -Wall --timing

SOURCES := $(wildcard verilog/*.sv) $(wildcard test/*.sv) $(wildcard test/*.svh)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "No errors" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
